//--- build.f
verilog/fpu_issue_pkg.sv
verilog/fpu_unit_pkg.sv
verilog/fpu_decoder.sv
verilog/fpu_hold_buffer.sv
verilog/fpu_noncomp_unit.sv
verilog/fpu_wrap.sv
testbench/fpu_checker.sv
testbench/tb_fpu_wrap.sv

//--- testbench/fpu_checker.sv
/* Scoreboard for the FP wrapper. Predicts every accepted request and
   compares the writeback stream against it in order, with latency. */

`timescale 1ns/1ps

module fpu_checker #(
    parameter int unsigned PIPE_STAGES = fpu_unit_pkg::PIPE_STAGES_DEFAULT
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  logic                               issue_valid_i,
    input  logic                               issue_ready_i,
    input  fpu_issue_pkg::issue_req_t          issue_req_i,
    input  logic                               wb_valid_i,
    input  logic                               wb_ready_i,
    input  logic [fpu_issue_pkg::FLEN-1:0]     result_i,
    input  logic [fpu_issue_pkg::TAG_BITS-1:0] tag_i,
    input  fpu_unit_pkg::status_t              status_i,
    output int unsigned                        error_count_o,
    output int unsigned                        checked_count_o,
    output int unsigned                        pending_count_o
);

    import fpu_issue_pkg::*;
    import fpu_unit_pkg::*;

    typedef struct packed {
        logic [FLEN-1:0]     result;
        logic [TAG_BITS-1:0] tag;
        status_t             status;
    } expect_t;

    expect_t     expect_q [$];             // Accepted, not yet written back
    int unsigned accept_q [$];             // Edge number of each acceptance
    int unsigned cycle = 0;                // Rising edges seen so far
    int unsigned last_stall = 0;           // Last edge with wb_ready_i low
    logic        check_reset_state = 1'b0;

    initial begin
        error_count_o   = 0;
        checked_count_o = 0;
        pending_count_o = 0;
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Unsigned key in numeric order, -0 sorts below +0
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != '0);
    endfunction

    // One-hot RISC-V fclass mask
    function automatic logic [9:0] class_mask(input logic [31:0] x);
        int unsigned bit_pos;
        if (x[30:23] == 8'hFF) begin
            bit_pos = (x[22:0] == '0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
        end else if (x[30:23] == 8'h00) begin
            bit_pos = (x[22:0] == '0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
        end else begin
            bit_pos = x[31] ? 1 : 6;   // Normal number
        end
        return 10'b1 << bit_pos;
    endfunction

    function automatic expect_t predict(input issue_req_t req);
        expect_t     want;
        logic [31:0] a;
        logic [31:0] b;
        logic        any_nan;
        logic        any_snan;
        logic        zeros;    // Both zero, either sign
        logic        a_below;
        a        = req.operand_a;
        b        = req.operand_b;
        any_nan  = is_nan(a) || is_nan(b);
        any_snan = (is_nan(a) && !a[22]) || (is_nan(b) && !b[22]);
        zeros    = (a[30:0] == '0) && (b[30:0] == '0);
        a_below  = order_key(a) < order_key(b);
        want     = '0;
        want.tag = req.tag;
        case (req.op)
            FSGNJ: begin
                case (req.rm[1:0])
                    2'd0:    want.result = {b[31], a[30:0]};
                    2'd1:    want.result = {~b[31], a[30:0]};
                    2'd2:    want.result = {a[31] ^ b[31], a[30:0]};
                    default: want.result = a;
                endcase
            end
            FMIN_MAX: begin
                want.status.nv = any_snan;
                if (is_nan(a) && is_nan(b)) begin
                    want.result = CANONICAL_NAN;
                end else if (any_nan) begin
                    want.result = is_nan(a) ? b : a;             // Number beats NaN
                end else begin
                    want.result = (req.rm[0] == a_below) ? b : a;  // rm[0] set is max
                end
            end
            FCMP: begin
                want.status.nv = (req.rm[1:0] == 2'd2) ? any_snan : any_nan;
                case (req.rm[1:0])
                    2'd0:    want.result[0] = !any_nan && (a_below || a == b || zeros);
                    2'd1:    want.result[0] = !any_nan && a_below && !zeros;
                    default: want.result[0] = !any_nan && (a == b || zeros);
                endcase
            end
            FCLASS:  want.result = {22'd0, class_mask(a)};
            default: want.result = a;  // Both moves
        endcase
        return want;
    endfunction

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count_o++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Compare process, sampled on the rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk_i) begin : compare
        expect_t     want;
        int unsigned accepted;
        cycle++;
        if (!wb_ready_i) last_stall = cycle;
        if (!rst_ni) begin
            expect_q.delete();
            accept_q.delete();
            check_reset_state = 1'b1;
        end else if (flush_i) begin
            if (issue_valid_i && issue_ready_i) begin
                $display("Request with tag %h was accepted during a flush at %0t ns",
                         issue_req_i.tag, $time);
                error_count_o++;
            end
            expect_q.delete();   // Flushed requests must never return
            accept_q.delete();
        end else begin
            if (check_reset_state) begin
                check_field("ready_o", 1, issue_ready_i);
                check_field("valid_o", 0, wb_valid_i);
                check_reset_state = 1'b0;
            end
            if (wb_valid_i && wb_ready_i) begin
                if (expect_q.size() == 0) begin
                    $display("Result with tag %h at %0t ns has no outstanding request",
                             tag_i, $time);
                    error_count_o++;
                end else begin
                    want     = expect_q.pop_front();
                    accepted = accept_q.pop_front();
                    check_field("result_o", want.result, result_i);
                    check_field("tag_o", want.tag, tag_i);
                    check_field("status_o", want.status, status_i);
                    // Fixed latency only holds with no back-pressure since acceptance
                    if (last_stall <= accepted) begin
                        check_field("valid_o latency", PIPE_STAGES, cycle - accepted);
                    end
                    checked_count_o++;
                end
            end
            if (issue_valid_i && issue_ready_i) begin
                expect_q.push_back(predict(issue_req_i));
                accept_q.push_back(cycle);
            end
        end
        pending_count_o = expect_q.size();
    end

endmodule

//--- testbench/tb_fpu_wrap.sv
/* Testbench top for the FP wrapper with clock, reset and request stimulus.
   fpu_checker runs alongside and does all result checking. */

`timescale 1ns/1ps

module tb_fpu_wrap;

    import fpu_issue_pkg::*;
    import fpu_unit_pkg::*;

    localparam int unsigned PIPE_STAGES = 3;
    localparam int unsigned TIMEOUT     = 1000;  // Cycles allowed per wait

    logic                clk_i;
    logic                rst_ni;
    logic                flush_i;
    logic                valid_i;
    logic                ready_o;
    issue_req_t          req_i;
    logic                valid_o;
    logic                wb_ready_i;
    logic [FLEN-1:0]     result_o;
    logic [TAG_BITS-1:0] tag_o;
    status_t             status_o;
    int unsigned         error_count;
    int unsigned         checked_count;
    int unsigned         pending_count;
    int unsigned         errors_before;
    logic [TAG_BITS-1:0] next_tag;
    logic                issue_done;   // Ends the random back-pressure process

    always #10 clk_i = ~clk_i;  // 20 ns period

    fpu_wrap #(.PIPE_STAGES(PIPE_STAGES)) fpu_wrap_inst (.*);

    fpu_checker #(.PIPE_STAGES(PIPE_STAGES)) fpu_checker_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .issue_valid_i   (valid_i),
        .issue_ready_i   (ready_o),
        .issue_req_i     (req_i),
        .wb_valid_i      (valid_o),
        .wb_ready_i      (wb_ready_i),
        .result_i        (result_o),
        .tag_i           (tag_o),
        .status_i        (status_o),
        .error_count_o   (error_count),
        .checked_count_o (checked_count),
        .pending_count_o (pending_count)
    );

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    function automatic logic [31:0] special_value(input int unsigned idx);
        case (idx)
            0:       return 32'h0000_0000;  // +0
            1:       return 32'h8000_0000;  // -0
            2:       return 32'h7F80_0000;  // +inf
            3:       return 32'hFF80_0000;  // -inf
            4:       return 32'h7FC0_0000;  // Quiet NaN
            5:       return 32'h7F80_0001;  // Signaling NaN
            6:       return 32'h807F_FFFF;  // Largest negative subnormal
            7:       return 32'h3F80_0000;  // 1.0
            8:       return 32'h7F7F_FFFF;
            default: return 32'hC040_0000;  // -3.0
        endcase
    endfunction

    function automatic logic [31:0] pick_value();
        return ($urandom_range(0, 3) == 0) ? special_value($urandom_range(0, 9)) : $urandom();
    endfunction

    // Offer one request from a falling edge until ready_o takes it
    task automatic send(input fu_op_e kind, input logic [2:0] rm,
                        input logic [31:0] a, input logic [31:0] b);
        int unsigned waited;
        logic        accepted;
        @(negedge clk_i);
        req_i.op        = kind;
        req_i.rm        = rm;
        req_i.operand_a = a;
        req_i.operand_b = b;
        req_i.tag       = next_tag;
        valid_i         = 1'b1;
        accepted        = 1'b0;
        waited          = 0;
        while (!accepted) begin
            @(posedge clk_i);
            accepted = ready_o;
            waited++;
            if (!accepted && waited >= TIMEOUT) stop_on_timeout("ready_o");
        end
        next_tag++;
    endtask

    task automatic send_random(input fu_op_e kind);
        logic [2:0] rm;
        case (kind)
            FMIN_MAX: rm = 3'($urandom_range(0, 1));
            FCMP:     rm = 3'($urandom_range(0, 2));
            default:  rm = 3'($urandom_range(0, 7));  // rm[2] unused
        endcase
        send(kind, rm, pick_value(), pick_value());
    endtask

    // Drop valid_i and wait until every accepted request has written back
    task automatic wait_drained();
        int unsigned waited;
        @(negedge clk_i);
        valid_i = 1'b0;
        waited  = 0;
        while (pending_count != 0) begin
            @(negedge clk_i);
            waited++;
            if (waited >= TIMEOUT) stop_on_timeout("outstanding results");
        end
    endtask

    task automatic drain_and_report(input int num, input string name);
        wait_drained();
        $display("Test %0d %s finished, %0d errors", num, name, error_count - errors_before);
        errors_before = error_count;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int unsigned guard;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        valid_i       = 1'b0;
        wb_ready_i    = 1'b1;
        req_i         = '0;
        next_tag      = '0;
        errors_before = 0;
        issue_done    = 1'b0;
        void'($urandom(23597));
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;

        // Single requests with the pipeline idle between them
        for (int n = 0; n < 4; n++) begin
            send(FCLASS, 3'd0, pick_value(), 32'd0);
            wait_drained();
        end
        drain_and_report(1, "reset and single-request latency");

        for (int n = 0; n < 60; n++) send_random(fu_op_e'($urandom_range(0, 2)));
        drain_and_report(2, "sign injection and moves");

        for (int n = 0; n < 200; n++) begin
            send(FMIN_MAX, 3'(n % 2), special_value(n / 20), special_value((n / 2) % 10));
        end
        drain_and_report(3, "min and max");

        for (int n = 0; n < 300; n++) begin
            send(FCMP, 3'(n % 3), special_value(n / 30), special_value((n / 3) % 10));
        end
        for (int n = 0; n < 10; n++) send(FCLASS, 3'd0, special_value(n), 32'd0);
        for (int n = 0; n < 60; n++) send_random((n % 2) ? FCMP : FCLASS);
        drain_and_report(4, "compare and classify");

        // Back-to-back requests against random writeback stalls
        guard = 0;
        fork
            begin
                for (int n = 0; n < 120; n++) send_random(fu_op_e'($urandom_range(0, 5)));
                issue_done = 1'b1;
            end
            while (!issue_done && guard < 100 * TIMEOUT) begin
                @(negedge clk_i);
                wb_ready_i = ($urandom_range(0, 2) != 0);
                guard++;
            end
        join
        wb_ready_i = 1'b1;
        drain_and_report(5, "random back-pressure");

        // Fill the pipeline, stall one more in the hold buffer, then flush
        @(negedge clk_i);
        wb_ready_i = 1'b0;
        for (int n = 0; n < PIPE_STAGES; n++) send_random(FSGNJ);
        @(negedge clk_i);
        req_i.tag = next_tag;
        next_tag++;
        @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i    = 1'b0;
        valid_i    = 1'b0;
        wb_ready_i = 1'b1;
        repeat (2 * PIPE_STAGES + 4) @(negedge clk_i);  // Flushed results would show here
        for (int n = 0; n < 20; n++) send_random(fu_op_e'($urandom_range(0, 5)));
        drain_and_report(6, "flush in flight");

        $display("Checked %0d results, %0d errors", checked_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- verilog/fpu_decoder.sv
/* Combinational decode of an issue request into a unit request.
   Maps operator and rm to op/op_sel and classifies both operands. */

`timescale 1ns/1ps

module fpu_decoder (
    input  fpu_issue_pkg::issue_req_t req_i,
    output fpu_unit_pkg::unit_req_t   unit_req_o
);

    import fpu_issue_pkg::*;
    import fpu_unit_pkg::*;

    // ------------------------------------------------------------------------
    // Operand classification
    // ------------------------------------------------------------------------
    function automatic fp_class_t classify(input logic [FLEN-1:0] value);
        logic [7:0]  exponent;
        logic [22:0] mantissa;
        logic        exp_ones;
        logic        exp_zero;
        fp_class_t   cls;
        exponent = value[30:23];
        mantissa = value[22:0];
        exp_ones = &exponent;
        exp_zero = ~|exponent;
        cls.sign         = value[FLEN-1];
        cls.is_zero      = exp_zero && (mantissa == '0);
        cls.is_subnormal = exp_zero && (mantissa != '0);
        cls.is_inf       = exp_ones && (mantissa == '0);
        cls.is_nan       = exp_ones && (mantissa != '0);
        cls.is_snan      = cls.is_nan && !mantissa[22];  // Quiet bit clear
        return cls;
    endfunction

    // ------------------------------------------------------------------------
    // Operator translation
    // ------------------------------------------------------------------------
    always_comb begin : translate
        // Defaults: sign injection, variant straight from rm
        unit_req_o.op        = SGNJ;
        unit_req_o.op_sel    = req_i.rm[1:0];
        unit_req_o.operand_a = req_i.operand_a;
        unit_req_o.operand_b = req_i.operand_b;
        unit_req_o.class_a   = classify(req_i.operand_a);
        unit_req_o.class_b   = classify(req_i.operand_b);
        unit_req_o.tag       = req_i.tag;

        case (req_i.op)
            FSGNJ: begin
                unit_req_o.op = SGNJ;  // 0 plain, 1 negated, 2 xored
            end
            // Moves need no recoding, pass operand A through
            FMV_F2X, FMV_X2F: begin
                unit_req_o.op     = SGNJ;
                unit_req_o.op_sel = 2'd3;
            end
            FMIN_MAX: begin
                unit_req_o.op = MINMAX;  // 0 min, 1 max
            end
            FCMP: begin
                unit_req_o.op = CMP;     // 0 le, 1 lt, 2 eq
            end
            FCLASS: begin
                unit_req_o.op = CLASSIFY;
            end
            default: begin
                // Unused encodings behave as a plain move
                unit_req_o.op     = SGNJ;
                unit_req_o.op_sel = 2'd3;
            end
        endcase
    end

endmodule

//--- verilog/fpu_hold_buffer.sv
/* Protocol inversion between issue and unit. A request that meets a busy
   unit is latched and replayed while the issue side sees ready low. */

`timescale 1ns/1ps

module fpu_hold_buffer (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  fpu_unit_pkg::unit_req_t req_i,
    output logic                    unit_valid_o,
    input  logic                    unit_ready_i,
    output fpu_unit_pkg::unit_req_t unit_req_o
);

    import fpu_unit_pkg::*;

    typedef enum logic {READY, STALL} state_e;

    state_e    state_q, state_d;
    logic      hold_inputs;  // Load the hold register
    logic      use_hold;     // Unit sees the held request
    unit_req_t hold_q;

    // ------------------------------------------------------------------------
    // READY/STALL FSM
    // ------------------------------------------------------------------------
    always_comb begin : fsm
        ready_o      = 1'b0;
        unit_valid_o = 1'b0;
        hold_inputs  = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        case (state_q)
            READY: begin
                ready_o      = 1'b1;     // Looks ready to issue
                unit_valid_o = valid_i;  // Live request straight through
                if (valid_i && !unit_ready_i) begin
                    ready_o     = 1'b0;  // Not accepted this cycle
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;
                use_hold     = 1'b1;
                // Token back to issue once the unit takes the held request
                if (unit_ready_i) begin
                    ready_o = 1'b1;
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush drops the held request and blocks this cycle's transfer
        if (flush_i) begin
            ready_o      = 1'b0;
            unit_valid_o = 1'b0;
            hold_inputs  = 1'b0;
            state_d      = READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin : hold_reg
        if (hold_inputs) begin
            hold_q <= req_i;
        end
    end

    assign unit_req_o = use_hold ? hold_q : req_i;  // Held or live request

endmodule

//--- verilog/fpu_issue_pkg.sv
/* Core-side view of the FP unit: operator encoding and the issue request.
   Imported by the decoder and by the top level for its port types. */

package fpu_issue_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int unsigned FLEN     = 32;  // FP32 only
    localparam int unsigned TAG_BITS = 4;   // Transaction id width

    // ------------------------------------------------------------------------
    // Core operator, as seen by the issue stage
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,  // Sign injection, variant in rm
        FMV_F2X  = 3'd1,  // FPR to GPR move
        FMV_X2F  = 3'd2,  // GPR to FPR move
        FMIN_MAX = 3'd3,  // Min or max, variant in rm
        FCMP     = 3'd4,  // Compare, variant in rm
        FCLASS   = 3'd5   // Classify
    } fu_op_e;

    // Issue request
    // rm carries the sub-operation for the non-computational ops
    typedef struct packed {
        fu_op_e              op;
        logic [2:0]          rm;
        logic [FLEN-1:0]     operand_a;
        logic [FLEN-1:0]     operand_b;
        logic [TAG_BITS-1:0] tag;
    } issue_req_t;

endpackage

//--- verilog/fpu_noncomp_unit.sv
/* Non-computational FP32 operations: sign injection, min/max, compare and
   classify, followed by a valid-tagged pipeline that freezes on stall. */

`timescale 1ns/1ps

module fpu_noncomp_unit #(
    parameter int unsigned PIPE_STAGES = fpu_unit_pkg::PIPE_STAGES_DEFAULT
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  logic                               in_valid_i,
    output logic                               in_ready_o,
    input  fpu_unit_pkg::unit_req_t            req_i,
    output logic                               out_valid_o,
    input  logic                               out_ready_i,
    output logic [fpu_issue_pkg::FLEN-1:0]     result_o,
    output logic [fpu_issue_pkg::TAG_BITS-1:0] tag_o,
    output fpu_unit_pkg::status_t              status_o
);

    import fpu_issue_pkg::*;
    import fpu_unit_pkg::*;

    // One pipeline entry
    typedef struct packed {
        logic [FLEN-1:0]     result;
        logic [TAG_BITS-1:0] tag;
        status_t             status;
    } stage_t;

    logic [FLEN-1:0]        op_a, op_b;
    fp_class_t              cls_a, cls_b;
    logic                   a_lt_b;       // Sign-magnitude order, -0 < +0
    logic                   both_zero;
    logic                   any_nan, any_snan;
    logic [9:0]             class_mask;
    stage_t                 stage_d;
    logic [PIPE_STAGES-1:0] valid_q;
    stage_t                 data_q [PIPE_STAGES];
    logic                   advance;

    assign op_a  = req_i.operand_a;
    assign op_b  = req_i.operand_b;
    assign cls_a = req_i.class_a;
    assign cls_b = req_i.class_b;

    // ------------------------------------------------------------------------
    // Shared comparison terms
    // ------------------------------------------------------------------------
    always_comb begin : order
        if (cls_a.sign != cls_b.sign) begin
            a_lt_b = cls_a.sign;                     // Negative side is smaller
        end else if (cls_a.sign) begin
            a_lt_b = op_a[FLEN-2:0] > op_b[FLEN-2:0];  // Both negative
        end else begin
            a_lt_b = op_a[FLEN-2:0] < op_b[FLEN-2:0];
        end
    end

    assign both_zero = cls_a.is_zero && cls_b.is_zero;
    assign any_nan   = cls_a.is_nan || cls_b.is_nan;
    assign any_snan  = cls_a.is_snan || cls_b.is_snan;

    // RISC-V class mask of operand A
    assign class_mask[0] = cls_a.sign && cls_a.is_inf;
    assign class_mask[1] = cls_a.sign && !(cls_a.is_zero || cls_a.is_subnormal
                                           || cls_a.is_inf || cls_a.is_nan);
    assign class_mask[2] = cls_a.sign && cls_a.is_subnormal;
    assign class_mask[3] = cls_a.sign && cls_a.is_zero;
    assign class_mask[4] = !cls_a.sign && cls_a.is_zero;
    assign class_mask[5] = !cls_a.sign && cls_a.is_subnormal;
    assign class_mask[6] = !cls_a.sign && !(cls_a.is_zero || cls_a.is_subnormal
                                            || cls_a.is_inf || cls_a.is_nan);
    assign class_mask[7] = !cls_a.sign && cls_a.is_inf;
    assign class_mask[8] = cls_a.is_snan;
    assign class_mask[9] = cls_a.is_nan && !cls_a.is_snan;

    // ------------------------------------------------------------------------
    // Result and flags
    // ------------------------------------------------------------------------
    always_comb begin : compute
        stage_d.result = '0;
        stage_d.tag    = req_i.tag;
        stage_d.status = '0;  // Only NV can be raised here

        case (req_i.op)
            SGNJ: begin
                case (req_i.op_sel)
                    2'd0:    stage_d.result = {cls_b.sign, op_a[FLEN-2:0]};
                    2'd1:    stage_d.result = {~cls_b.sign, op_a[FLEN-2:0]};
                    2'd2:    stage_d.result = {cls_a.sign ^ cls_b.sign, op_a[FLEN-2:0]};
                    default: stage_d.result = op_a;  // Moves
                endcase
            end
            MINMAX: begin
                stage_d.status.nv = any_snan;
                if (cls_a.is_nan && cls_b.is_nan) begin
                    stage_d.result = CANONICAL_NAN;
                end else if (cls_a.is_nan) begin
                    stage_d.result = op_b;
                end else if (cls_b.is_nan) begin
                    stage_d.result = op_a;
                end else if (req_i.op_sel[0]) begin
                    stage_d.result = a_lt_b ? op_b : op_a;  // Max
                end else begin
                    stage_d.result = a_lt_b ? op_a : op_b;  // Min
                end
            end
            CMP: begin
                case (req_i.op_sel)
                    2'd0: begin  // le
                        stage_d.status.nv = any_nan;
                        stage_d.result[0] = !any_nan && (a_lt_b || op_a == op_b || both_zero);
                    end
                    2'd1: begin  // lt, +0 and -0 compare equal
                        stage_d.status.nv = any_nan;
                        stage_d.result[0] = !any_nan && a_lt_b && !both_zero;
                    end
                    2'd2: begin  // eq, quiet NaNs stay silent
                        stage_d.status.nv = any_snan;
                        stage_d.result[0] = !any_nan && (op_a == op_b || both_zero);
                    end
                    default: stage_d.result = '0;
                endcase
            end
            default: stage_d.result = {{(FLEN-10){1'b0}}, class_mask};  // CLASSIFY
        endcase
    end

    // ------------------------------------------------------------------------
    // Stallable pipeline
    // ------------------------------------------------------------------------
    assign advance    = !valid_q[PIPE_STAGES-1] || out_ready_i;  // Last stage free or leaving
    assign in_ready_o = advance;

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_regs
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;  // Drop everything in flight
        end else if (advance) begin
            valid_q[0] <= in_valid_i;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin : data_regs
        if (advance) begin
            data_q[0] <= stage_d;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end
    end

    assign out_valid_o = valid_q[PIPE_STAGES-1];
    assign result_o    = data_q[PIPE_STAGES-1].result;
    assign tag_o       = data_q[PIPE_STAGES-1].tag;
    assign status_o    = data_q[PIPE_STAGES-1].status;

endmodule

//--- verilog/fpu_unit_pkg.sv
/* Unit-side types: operation, operand class, unit request and status flags.
   Shared by the decoder, the hold buffer and the non-computational unit. */

package fpu_unit_pkg;

    // ------------------------------------------------------------------------
    // Unit operation
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        SGNJ     = 2'd0,  // Sign injection and moves
        MINMAX   = 2'd1,
        CMP      = 2'd2,
        CLASSIFY = 2'd3
    } unit_op_e;

    // Operand class, computed once in the decoder
    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_inf;
        logic is_subnormal;
        logic is_nan;
        logic is_snan;      // Signaling NaN, subset of is_nan
    } fp_class_t;

    // Request as it enters the unit
    typedef struct packed {
        unit_op_e                          op;
        logic [1:0]                        op_sel;  // Variant within op
        logic [fpu_issue_pkg::FLEN-1:0]     operand_a;
        logic [fpu_issue_pkg::FLEN-1:0]     operand_b;
        fp_class_t                         class_a;
        fp_class_t                         class_b;
        logic [fpu_issue_pkg::TAG_BITS-1:0] tag;
    } unit_req_t;

    // IEEE status flags, RISC-V fflags order
    typedef struct packed {
        logic nv;  // Invalid
        logic dz;  // Divide by zero
        logic of;  // Overflow
        logic uf;  // Underflow
        logic nx;  // Inexact
    } status_t;

    // ------------------------------------------------------------------------
    // Constants
    // ------------------------------------------------------------------------
    localparam logic [31:0] CANONICAL_NAN       = 32'h7FC0_0000;
    localparam int unsigned PIPE_STAGES_DEFAULT = 2;

endpackage

//--- verilog/fpu_wrap.sv
/* Top level of the non-computational FP wrapper: decoder, hold buffer and
   pipelined unit in a chain. PIPE_STAGES sets the unit latency. */

`timescale 1ns/1ps

module fpu_wrap #(
    parameter int unsigned PIPE_STAGES = fpu_unit_pkg::PIPE_STAGES_DEFAULT
) (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               flush_i,
    input  logic                               valid_i,
    output logic                               ready_o,
    input  fpu_issue_pkg::issue_req_t          req_i,
    output logic                               valid_o,
    input  logic                               wb_ready_i,
    output logic [fpu_issue_pkg::FLEN-1:0]     result_o,
    output logic [fpu_issue_pkg::TAG_BITS-1:0] tag_o,
    output fpu_unit_pkg::status_t              status_o
);

    import fpu_unit_pkg::*;

    unit_req_t dec_req;      // Decoded live request
    unit_req_t unit_req;     // Live or held, toward the unit
    logic      unit_valid;
    logic      unit_ready;

    fpu_decoder fpu_decoder_inst (
        .req_i      (req_i),
        .unit_req_o (dec_req)
    );

    fpu_hold_buffer fpu_hold_buffer_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .req_i        (dec_req),
        .unit_valid_o (unit_valid),
        .unit_ready_i (unit_ready),
        .unit_req_o   (unit_req)
    );

    fpu_noncomp_unit #(
        .PIPE_STAGES (PIPE_STAGES)
    ) fpu_noncomp_unit_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (unit_valid),
        .in_ready_o  (unit_ready),
        .req_i       (unit_req),
        .out_valid_o (valid_o),
        .out_ready_i (wb_ready_i),  // Writeback back-pressure
        .result_o    (result_o),
        .tag_o       (tag_o),
        .status_o    (status_o)
    );

endmodule
